// File: Makefile
# Verilator build and run of the coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_coproc
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+source
source/coproc_pkg.sv
source/slot_ram.sv
source/mod_addsub_pipe.sv
source/inst_sequencer.sv
source/interrupt_tx.sv
source/coproc_top.sv
tests/tb_coproc.sv

// File: source/coproc_defines.svh
/*
  Global sizes and constants of the coprocessor core.
  Include this file wherever a width, a depth or the modulus is needed.
  The include guard keeps repeated includes harmless.
*/
`ifndef COPROC_DEFINES_SVH
`define COPROC_DEFINES_SVH

// Field element width and its prime modulus
`define FE_BITS 32
`define FE_PRIME 32'hFFFFFFFB

// Address widths of the slot RAM and the instruction RAM
`define SLOT_ADDR_BITS 8
`define INST_ADDR_BITS 8

// Cycles from a port B read strobe to valid data
`define READ_CYCLE 2

// Beats buffered for outgoing interrupt packets
`define IRQ_FIFO_DEPTH 8

// Width of one outgoing stream beat
`define TX_BITS 64

`endif

// File: source/coproc_pkg.sv
/*
  Shared types of the coprocessor core: opcodes, the slot and
  instruction words, the host write word and the interrupt beats.
  Modules import it inside their body and use scoped names in ports.
*/
`default_nettype none

`include "coproc_defines.svh"

package coproc_pkg;

  typedef enum logic [7:0] {
    NOOP_WAIT        = 8'h00,
    COPY_REG         = 8'h01,
    JUMP             = 8'h02,
    JUMP_IF_EQ       = 8'h03,
    JUMP_NONZERO_SUB = 8'h04,
    SEND_INTERRUPT   = 8'h06,
    ADD_ELEMENT      = 8'h0C,
    SUB_ELEMENT      = 8'h10
  } opcode_t;

  typedef enum logic [2:0] {
    SCALAR = 3'd0,
    FE     = 3'd1
  } slot_type_t;

  // One slot RAM entry, tag in the top bits
  typedef struct packed {
    slot_type_t              tag;
    logic [`FE_BITS-1:0]     dat;
  } slot_t;

  typedef struct packed {
    opcode_t                 code;
    logic [15:0]             a;
    logic [15:0]             b;
    logic [15:0]             c;
  } inst_t;

  typedef enum logic {
    WR_INST = 1'b0,
    WR_SLOT = 1'b1
  } wr_target_t;

  // Host write, payload low bits hold the entry
  typedef struct packed {
    wr_target_t                  target;
    logic [`SLOT_ADDR_BITS-1:0]  addr;
    logic [63:0]                 payload;
  } usr_wr_t;

  typedef struct packed {
    logic                    last;
    logic                    hdr;
    logic [`TX_BITS-1:0]     dat;
  } irq_beat_t;

  typedef struct packed {
    logic [`TX_BITS-1:0]     dat;
    logic                    sop;
    logic                    eop;
  } tx_beat_t;

endpackage

`default_nettype wire

// File: source/coproc_top.sv
/*
  Top level of the coprocessor core.
  The host loads both RAMs through a plain write port and starts a
  program with a start pulse. Results leave as interrupt packets on
  a 64-bit valid/ready stream.
*/
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module coproc_top (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_usr_wr_en,
  input  coproc_pkg::usr_wr_t         i_usr_wr,
  input  logic                        i_start,
  input  logic [`INST_ADDR_BITS-1:0]  i_start_pt,
  output logic                        o_tx_val,
  output coproc_pkg::tx_beat_t        o_tx,
  input  logic                        i_tx_rdy
);

  import coproc_pkg::*;

  logic                        inst_usr_we;
  logic                        slot_usr_we;
  logic                        inst_re;
  logic [`INST_ADDR_BITS-1:0]  inst_addr;
  inst_t                       inst_q;
  logic                        slot_re;
  logic                        slot_we;
  logic [`SLOT_ADDR_BITS-1:0]  slot_addr;
  slot_t                       slot_d;
  slot_t                       slot_q;
  logic                        op_val;
  logic                        op_sub;
  logic [`FE_BITS-1:0]         op_a;
  logic [`FE_BITS-1:0]         op_b;
  logic                        res_val;
  logic [`FE_BITS-1:0]         res;
  logic                        irq_push;
  irq_beat_t                   irq_beat;
  logic                        irq_full;

  // Host write strobe steered by target
  assign inst_usr_we = i_usr_wr_en && (i_usr_wr.target == WR_INST);
  assign slot_usr_we = i_usr_wr_en && (i_usr_wr.target == WR_SLOT);

  slot_ram #(.entry_t(inst_t), .DEPTH_BITS(`INST_ADDR_BITS)) u_inst_ram (
    .i_clk    (i_clk),
    .i_a_we   (inst_usr_we),
    .i_a_addr (i_usr_wr.addr),
    .i_a_d    (inst_t'(i_usr_wr.payload[$bits(inst_t)-1:0])),
    .i_b_re   (inst_re),
    .i_b_we   (1'b0),
    .i_b_addr (inst_addr),
    .i_b_d    ('0),
    .o_b_q    (inst_q)
  );

  slot_ram #(.entry_t(slot_t), .DEPTH_BITS(`SLOT_ADDR_BITS)) u_slot_ram (
    .i_clk    (i_clk),
    .i_a_we   (slot_usr_we),
    .i_a_addr (i_usr_wr.addr),
    .i_a_d    (slot_t'(i_usr_wr.payload[$bits(slot_t)-1:0])),
    .i_b_re   (slot_re),
    .i_b_we   (slot_we),
    .i_b_addr (slot_addr),
    .i_b_d    (slot_d),
    .o_b_q    (slot_q)
  );

  inst_sequencer u_seq (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (i_start),
    .i_start_pt  (i_start_pt),
    .o_inst_re   (inst_re),
    .o_inst_addr (inst_addr),
    .i_inst      (inst_q),
    .o_slot_re   (slot_re),
    .o_slot_we   (slot_we),
    .o_slot_addr (slot_addr),
    .o_slot_d    (slot_d),
    .i_slot      (slot_q),
    .o_op_val    (op_val),
    .o_op_sub    (op_sub),
    .o_op_a      (op_a),
    .o_op_b      (op_b),
    .i_res_val   (res_val),
    .i_res       (res),
    .o_irq_push  (irq_push),
    .o_irq_beat  (irq_beat),
    .i_irq_full  (irq_full)
  );

  mod_addsub_pipe u_addsub (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_op_val  (op_val),
    .i_sub     (op_sub),
    .i_a       (op_a),
    .i_b       (op_b),
    .o_res_val (res_val),
    .o_res     (res)
  );

  interrupt_tx u_irq_tx (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_irq_push (irq_push),
    .i_irq_beat (irq_beat),
    .o_irq_full (irq_full),
    .o_tx_val   (o_tx_val),
    .o_tx       (o_tx),
    .i_tx_rdy   (i_tx_rdy)
  );

endmodule

`default_nettype wire

// File: source/inst_sequencer.sv
/*
  Fetch, decode and execute engine of the coprocessor.
  Owns port B of the instruction RAM and the slot RAM, feeds the
  add/sub pipe and queues interrupt beats. Idles in NOOP_WAIT until
  a start pulse gives a new instruction pointer.
*/
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module inst_sequencer (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_start,
  input  logic [`INST_ADDR_BITS-1:0]  i_start_pt,
  output logic                        o_inst_re,
  output logic [`INST_ADDR_BITS-1:0]  o_inst_addr,
  input  coproc_pkg::inst_t           i_inst,
  output logic                        o_slot_re,
  output logic                        o_slot_we,
  output logic [`SLOT_ADDR_BITS-1:0]  o_slot_addr,
  output coproc_pkg::slot_t           o_slot_d,
  input  coproc_pkg::slot_t           i_slot,
  output logic                        o_op_val,
  output logic                        o_op_sub,
  output logic [`FE_BITS-1:0]         o_op_a,
  output logic [`FE_BITS-1:0]         o_op_b,
  input  logic                        i_res_val,
  input  logic [`FE_BITS-1:0]         i_res,
  output logic                        o_irq_push,
  output coproc_pkg::irq_beat_t       o_irq_beat,
  input  logic                        i_irq_full
);

  import coproc_pkg::*;

  // Header holds tag [15:0], first slot type, then count
  localparam int HDR_PAD = `TX_BITS - 32 - $bits(slot_type_t);
  localparam int DAT_PAD = `TX_BITS - $bits(slot_t);

  opcode_t                      state;
  logic [2:0]                   cnt;
  inst_t                        inst_q;
  slot_t                        hold_q;
  logic [`INST_ADDR_BITS-1:0]   next_pt;
  logic [15:0]                  remain;
  logic [`READ_CYCLE:0]         inst_rd;
  logic [`READ_CYCLE:0]         slot_rd;
  logic                         can_push;
  logic [`SLOT_ADDR_BITS-1:0]   slot_a;
  logic [`SLOT_ADDR_BITS-1:0]   slot_b;
  logic [`SLOT_ADDR_BITS-1:0]   slot_c;
  logic [`INST_ADDR_BITS-1:0]   jump_pt;
  logic [`INST_ADDR_BITS-1:0]   pc_inc;

  assign slot_a  = inst_q.a[`SLOT_ADDR_BITS-1:0];
  assign slot_b  = inst_q.b[`SLOT_ADDR_BITS-1:0];
  assign slot_c  = inst_q.c[`SLOT_ADDR_BITS-1:0];
  assign jump_pt = inst_q.a[`INST_ADDR_BITS-1:0];
  assign pc_inc  = o_inst_addr + 1'b1;

  // A pending push is not yet counted in the FIFO level
  assign can_push = !i_irq_full && !o_irq_push;

  task automatic next_inst(input logic [`INST_ADDR_BITS-1:0] pt);
    if (inst_rd == '0) begin
      o_inst_addr <= pt;
      o_inst_re   <= 1'b1;
      inst_rd[0]  <= 1'b1;
    end
    if (inst_rd[`READ_CYCLE]) begin
      inst_q <= i_inst;
      state  <= i_inst.code;
      cnt    <= '0;
    end
  endtask

  task automatic read_slot(input logic [`SLOT_ADDR_BITS-1:0] addr);
    o_slot_addr <= addr;
    o_slot_re   <= 1'b1;
    slot_rd[0]  <= 1'b1;
  endtask

  task automatic write_slot(input logic [`SLOT_ADDR_BITS-1:0] addr, input slot_t d);
    o_slot_addr <= addr;
    o_slot_we   <= 1'b1;
    o_slot_d    <= d;
  endtask

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= NOOP_WAIT;
      cnt         <= '0;
      o_inst_addr <= '0;
      o_inst_re   <= 1'b0;
      o_slot_re   <= 1'b0;
      o_slot_we   <= 1'b0;
      o_op_val    <= 1'b0;
      o_irq_push  <= 1'b0;
      inst_rd     <= '0;
      slot_rd     <= '0;
    end else begin
      o_inst_re  <= 1'b0;
      o_slot_re  <= 1'b0;
      o_slot_we  <= 1'b0;
      o_op_val   <= 1'b0;
      o_irq_push <= 1'b0;
      inst_rd    <= inst_rd << 1;
      slot_rd    <= slot_rd << 1;

      case (state)
        NOOP_WAIT: begin
          if (cnt == 3'd0) begin
            if (i_start) begin
              next_inst(i_start_pt);
              cnt <= 3'd1;
            end
          end else begin
            next_inst(o_inst_addr);
          end
        end
        JUMP: next_inst(jump_pt);
        JUMP_IF_EQ: begin
          case (cnt)
            3'd0: begin
              read_slot(slot_b);
              cnt <= 3'd1;
            end
            3'd1: begin
              if (slot_rd[`READ_CYCLE]) begin
                hold_q <= i_slot;
                read_slot(slot_c);
                cnt <= 3'd2;
              end
            end
            3'd2: begin
              if (slot_rd[`READ_CYCLE]) begin
                next_pt <= (hold_q.dat == i_slot.dat) ? jump_pt : pc_inc;
                cnt <= 3'd3;
              end
            end
            default: next_inst(next_pt);
          endcase
        end
        JUMP_NONZERO_SUB: begin
          case (cnt)
            3'd0: begin
              read_slot(slot_b);
              cnt <= 3'd1;
            end
            3'd1: begin
              if (slot_rd[`READ_CYCLE]) begin
                if (i_slot.dat != '0) begin
                  write_slot(slot_b, '{tag: i_slot.tag, dat: i_slot.dat - 1'b1});
                  next_pt <= jump_pt;
                end else begin
                  next_pt <= pc_inc;
                end
                cnt <= 3'd2;
              end
            end
            default: next_inst(next_pt);
          endcase
        end
        COPY_REG: begin
          case (cnt)
            3'd0: begin
              read_slot(slot_a);
              cnt <= 3'd1;
            end
            3'd1: begin
              if (slot_rd[`READ_CYCLE]) begin
                write_slot(slot_b, i_slot);
                cnt <= 3'd2;
              end
            end
            default: next_inst(pc_inc);
          endcase
        end
        ADD_ELEMENT, SUB_ELEMENT: begin
          case (cnt)
            3'd0: begin
              read_slot(slot_a);
              cnt <= 3'd1;
            end
            3'd1: begin
              if (slot_rd[`READ_CYCLE]) begin
                hold_q <= i_slot;
                read_slot(slot_b);
                cnt <= 3'd2;
              end
            end
            3'd2: begin
              if (slot_rd[`READ_CYCLE]) begin
                o_op_a   <= hold_q.dat;
                o_op_b   <= i_slot.dat;
                o_op_sub <= (state == SUB_ELEMENT);
                o_op_val <= 1'b1;
                cnt <= 3'd3;
              end
            end
            3'd3: begin
              // Result keeps the type of slot a
              if (i_res_val) begin
                write_slot(slot_c, '{tag: hold_q.tag, dat: i_res});
                cnt <= 3'd4;
              end
            end
            default: next_inst(pc_inc);
          endcase
        end
        SEND_INTERRUPT: begin
          case (cnt)
            3'd0: begin
              read_slot(slot_a);
              remain <= inst_q.c;
              cnt <= 3'd1;
            end
            3'd1: begin
              if (slot_rd[`READ_CYCLE]) begin
                hold_q <= i_slot;
                cnt <= 3'd2;
              end
            end
            3'd2: begin
              if (can_push) begin
                o_irq_push      <= 1'b1;
                o_irq_beat.last <= (remain == '0);
                o_irq_beat.hdr  <= 1'b1;
                o_irq_beat.dat  <= {{HDR_PAD{1'b0}}, inst_q.c, hold_q.tag, inst_q.b};
                cnt <= (remain == '0) ? 3'd5 : 3'd3;
              end
            end
            3'd3: begin
              if (can_push) begin
                o_irq_push      <= 1'b1;
                o_irq_beat.last <= (remain == 16'd1);
                o_irq_beat.hdr  <= 1'b0;
                o_irq_beat.dat  <= {{DAT_PAD{1'b0}}, hold_q};
                remain <= remain - 1'b1;
                if (remain == 16'd1) begin
                  cnt <= 3'd5;
                end else begin
                  read_slot(o_slot_addr + 1'b1);
                  cnt <= 3'd4;
                end
              end
            end
            3'd4: begin
              if (slot_rd[`READ_CYCLE]) begin
                hold_q <= i_slot;
                cnt <= 3'd3;
              end
            end
            default: next_inst(pc_inc);
          endcase
        end
        default: next_inst(pc_inc);
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/interrupt_tx.sv
/*
  Interrupt packet sender.
  Buffers beats from the sequencer in a small circular FIFO and drives
  the outgoing valid/ready stream from an output register.
  Header and last flags become sop and eop.
*/
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module interrupt_tx (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_irq_push,
  input  coproc_pkg::irq_beat_t  i_irq_beat,
  output logic                   o_irq_full,
  output logic                   o_tx_val,
  output coproc_pkg::tx_beat_t   o_tx,
  input  logic                   i_tx_rdy
);

  import coproc_pkg::*;

  localparam int DEPTH    = `IRQ_FIFO_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);

  irq_beat_t            fifo_mem [DEPTH];
  irq_beat_t            head;
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [PTR_BITS:0]    level;
  logic                 push;
  logic                 pop;

  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_irq_full = (level == (PTR_BITS+1)'(DEPTH));
  assign head       = fifo_mem[rd_ptr];
  assign push       = i_irq_push && !o_irq_full;
  // Refill the output register when empty or on a transfer
  assign pop        = (level != '0) && (!o_tx_val || i_tx_rdy);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      o_tx_val <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
      if (pop) begin
        o_tx_val <= 1'b1;
      end else if (i_tx_rdy) begin
        o_tx_val <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= i_irq_beat;
    end
    if (pop) begin
      o_tx.dat <= head.dat;
      o_tx.sop <= head.hdr;
      o_tx.eop <= head.last;
    end
  end

endmodule

`default_nettype wire

// File: source/mod_addsub_pipe.sv
/*
  Two-stage modular adder and subtractor for field elements.
  A result appears exactly two cycles after i_op_val, with no stall.
  Inputs must already be reduced below the prime.
*/
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module mod_addsub_pipe (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_op_val,
  input  logic                 i_sub,
  input  logic [`FE_BITS-1:0]  i_a,
  input  logic [`FE_BITS-1:0]  i_b,
  output logic                 o_res_val,
  output logic [`FE_BITS-1:0]  o_res
);

  localparam logic [`FE_BITS:0] PRIME_X = {1'b0, `FE_PRIME};

  logic                 s1_val;
  logic                 s1_sub;
  logic [`FE_BITS:0]    s1_raw;
  logic [`FE_BITS:0]    s2_fix;
  logic [`FE_BITS-1:0]  s2_res;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val    <= 1'b0;
      o_res_val <= 1'b0;
    end else begin
      s1_val    <= i_op_val;
      o_res_val <= s1_val;
    end
  end

  // Top bit of the raw value is the carry or the borrow
  always_ff @(posedge i_clk) begin
    s1_sub <= i_sub;
    if (i_sub) begin
      s1_raw <= {1'b0, i_a} - {1'b0, i_b};
    end else begin
      s1_raw <= {1'b0, i_a} + {1'b0, i_b};
    end
    o_res <= s2_res;
  end

  // One correction by the prime is always enough
  always_comb begin
    s2_fix = s1_sub ? s1_raw + PRIME_X : s1_raw - PRIME_X;
    if (s1_sub) begin
      s2_res = s1_raw[`FE_BITS] ? s2_fix[`FE_BITS-1:0] : s1_raw[`FE_BITS-1:0];
    end else begin
      s2_res = (s1_raw >= PRIME_X) ? s2_fix[`FE_BITS-1:0] : s1_raw[`FE_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/slot_ram.sv
/*
  Dual-port RAM with a fixed read latency on port B.
  Port A is a write-only host port, port B reads and writes for the core.
  The entry type is a parameter, so one block serves both RAMs.
*/
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module slot_ram #(
  parameter type entry_t    = logic [7:0],
  parameter int  DEPTH_BITS = 8
) (
  input  logic                   i_clk,
  input  logic                   i_a_we,
  input  logic [DEPTH_BITS-1:0]  i_a_addr,
  input  entry_t                 i_a_d,
  input  logic                   i_b_re,
  input  logic                   i_b_we,
  input  logic [DEPTH_BITS-1:0]  i_b_addr,
  input  entry_t                 i_b_d,
  output entry_t                 o_b_q
);

  entry_t mem [2**DEPTH_BITS];
  entry_t rd_pipe [`READ_CYCLE];

  always_ff @(posedge i_clk) begin
    if (i_a_we) begin
      mem[i_a_addr] <= i_a_d;
    end
    if (i_b_we) begin
      mem[i_b_addr] <= i_b_d;
    end
  end

  // Read data holds in the pipe until the next strobe
  always_ff @(posedge i_clk) begin
    if (i_b_re) begin
      rd_pipe[0] <= mem[i_b_addr];
    end
    for (int i = 1; i < `READ_CYCLE; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign o_b_q = rd_pipe[`READ_CYCLE-1];

endmodule

`default_nettype wire

// File: tests/tb_coproc.sv
/*
  Directed testbench for the coprocessor core.
  Loads small programs through the host write port, pulses start and
  checks the interrupt packets that come out on the stream.
  Each test is a task that prints one line when it finishes.
*/
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module tb_coproc;

  import coproc_pkg::*;

  localparam logic [31:0] PRIME        = `FE_PRIME;
  localparam int          PKT_TIMEOUT  = 1000;
  localparam int          QUIET_CYCLES = 12;

  logic                        i_clk;
  logic                        i_rst;
  logic                        i_usr_wr_en;
  usr_wr_t                     i_usr_wr;
  logic                        i_start;
  logic [`INST_ADDR_BITS-1:0]  i_start_pt;
  logic                        o_tx_val;
  tx_beat_t                    o_tx;
  logic                        i_tx_rdy;

  integer  seed;
  int      errors;
  int      checks;
  int      tests;
  slot_t   exp_q[$];

  coproc_top UUT (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_usr_wr_en (i_usr_wr_en),
    .i_usr_wr    (i_usr_wr),
    .i_start     (i_start),
    .i_start_pt  (i_start_pt),
    .o_tx_val    (o_tx_val),
    .o_tx        (o_tx),
    .i_tx_rdy    (i_tx_rdy)
  );

  always #10 i_clk = ~i_clk;

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("At %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic apply_reset();
    i_rst = 1'b1;
    repeat (10) next_cycle();
    i_rst = 1'b0;
  endtask

  function automatic slot_t mk_slot(input slot_type_t t, input logic [31:0] d);
    slot_t s;
    s.tag = t;
    s.dat = d;
    return s;
  endfunction

  function automatic logic [31:0] rand_fe();
    logic [31:0] r;
    r = $random(seed);
    return r % PRIME;
  endfunction

  function automatic logic [31:0] mod_add(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] s;
    s = ({32'd0, a} + {32'd0, b}) % {32'd0, PRIME};
    return s[31:0];
  endfunction

  function automatic logic [31:0] mod_sub(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] s;
    s = ({32'd0, a} + {32'd0, PRIME} - {32'd0, b}) % {32'd0, PRIME};
    return s[31:0];
  endfunction

  // Data beat is the slot zero-extended
  function automatic logic [63:0] beat_of_slot(input slot_t s);
    return {29'd0, s.tag, s.dat};
  endfunction

  task automatic write_inst(input int addr, input opcode_t code,
                            input int a, input int b, input int c);
    inst_t inst;
    inst.code = code;
    inst.a    = 16'(a);
    inst.b    = 16'(b);
    inst.c    = 16'(c);
    i_usr_wr.target  = WR_INST;
    i_usr_wr.addr    = `SLOT_ADDR_BITS'(addr);
    i_usr_wr.payload = {8'd0, inst};
    i_usr_wr_en      = 1'b1;
    next_cycle();
    i_usr_wr_en      = 1'b0;
  endtask

  task automatic write_slot(input int addr, input slot_t s);
    i_usr_wr.target  = WR_SLOT;
    i_usr_wr.addr    = `SLOT_ADDR_BITS'(addr);
    i_usr_wr.payload = {29'd0, s};
    i_usr_wr_en      = 1'b1;
    next_cycle();
    i_usr_wr_en      = 1'b0;
  endtask

  task automatic start_prog(input int pt);
    i_start_pt = `INST_ADDR_BITS'(pt);
    i_start    = 1'b1;
    next_cycle();
    i_start    = 1'b0;
  endtask

  // Gathers one packet and compares it with exp_q
  task automatic collect_packet(input logic [15:0] tag, input slot_type_t htype,
                                input bit rand_rdy);
    tx_beat_t     got[$];
    tx_beat_t     held;
    logic         stalled;
    logic [31:0]  r;
    int           cycles;
    bit           done;
    stalled = 1'b0;
    held    = '0;
    cycles  = 0;
    done    = 1'b0;
    while (!done && cycles < PKT_TIMEOUT) begin
      next_cycle();
      cycles++;
      if (rand_rdy) begin
        r = $random(seed);
        i_tx_rdy = r[0];
      end else begin
        i_tx_rdy = 1'b1;
      end
      // A stalled beat must hold until it transfers
      if (stalled) begin
        check_true(o_tx_val, "o_tx_val dropped while the stream was stalled");
        check_val("o_tx.dat", o_tx.dat, held.dat);
        check_val("o_tx.sop", 64'(o_tx.sop), 64'(held.sop));
        check_val("o_tx.eop", 64'(o_tx.eop), 64'(held.eop));
      end
      stalled = o_tx_val && !i_tx_rdy;
      held    = o_tx;
      if (o_tx_val && i_tx_rdy) begin
        got.push_back(o_tx);
        done = o_tx.eop;
      end
    end
    i_tx_rdy = 1'b1;
    if (!done) begin
      $display("At %0t: packet with tag %0h did not complete within %0d cycles",
               $time, tag, PKT_TIMEOUT);
      errors++;
    end else begin
      check_val("beat count", 64'(got.size()), 64'(exp_q.size() + 1));
      check_val("hdr.sop", 64'(got[0].sop), 64'd1);
      check_val("hdr.eop", 64'(got[0].eop), 64'(exp_q.size() == 0));
      check_val("hdr.tag", 64'(got[0].dat[15:0]), 64'(tag));
      check_val("hdr.type", 64'(got[0].dat[18:16]), 64'(htype));
      check_val("hdr.count", 64'(got[0].dat[34:19]), 64'(exp_q.size()));
      check_val("hdr.pad", 64'(got[0].dat[63:35]), 64'd0);
      for (int i = 1; i < got.size(); i++) begin
        check_val("data.sop", 64'(got[i].sop), 64'd0);
        check_val("data.eop", 64'(got[i].eop), 64'(i == got.size() - 1));
        if (i <= exp_q.size()) begin
          check_val("data", got[i].dat, beat_of_slot(exp_q[i-1]));
        end
      end
    end
  endtask

  // Also gives the program time to settle back in NOOP_WAIT
  task automatic expect_quiet(input int cycles);
    i_tx_rdy = 1'b1;
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      check_true(!o_tx_val, "a beat arrived outside the expected packet");
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("%s finished with %0d errors", name, errors - err0);
  endtask

  task automatic test_copy_send();
    int     err0;
    slot_t  src;
    err0 = errors;
    src  = mk_slot(FE, rand_fe());
    write_slot(3, src);
    write_slot(10, mk_slot(SCALAR, ~src.dat));
    write_inst(0, COPY_REG, 3, 10, 0);
    write_inst(1, SEND_INTERRUPT, 10, 'h00AB, 1);
    write_inst(2, NOOP_WAIT, 0, 0, 0);
    exp_q.delete();
    exp_q.push_back(src);
    start_prog(0);
    collect_packet(16'h00AB, FE, 1'b0);
    expect_quiet(QUIET_CYCLES);
    end_test("copy_send", err0);
  endtask

  task automatic run_addsub(input bit sub, input int pbase, input int tag, input string name);
    int           err0;
    slot_t        sa;
    slot_t        sb;
    logic [31:0]  va;
    logic [31:0]  vb;
    err0 = errors;
    exp_q.delete();
    for (int i = 0; i < 8; i++) begin
      va = rand_fe();
      vb = rand_fe();
      // First pair wraps around the prime
      if (i == 0) begin
        if (sub) begin
          va = 32'd1;
          vb = PRIME - 32'd1;
        end else begin
          va = PRIME - 32'd1;
          vb = PRIME - 32'd2;
        end
      end
      if ((i % 2) == 0) begin
        sa = mk_slot(FE, va);
        sb = mk_slot(SCALAR, vb);
      end else begin
        sa = mk_slot(SCALAR, va);
        sb = mk_slot(FE, vb);
      end
      write_slot(20 + i, sa);
      write_slot(30 + i, sb);
      if (sub) begin
        write_inst(pbase + i, SUB_ELEMENT, 20 + i, 30 + i, 40 + i);
        exp_q.push_back(mk_slot(sa.tag, mod_sub(va, vb)));
      end else begin
        write_inst(pbase + i, ADD_ELEMENT, 20 + i, 30 + i, 40 + i);
        exp_q.push_back(mk_slot(sa.tag, mod_add(va, vb)));
      end
    end
    write_inst(pbase + 8, SEND_INTERRUPT, 40, tag, 8);
    write_inst(pbase + 9, NOOP_WAIT, 0, 0, 0);
    start_prog(pbase);
    collect_packet(16'(tag), exp_q[0].tag, 1'b0);
    expect_quiet(QUIET_CYCLES);
    end_test(name, err0);
  endtask

  task automatic test_mod_add();
    run_addsub(1'b0, 16, 'h0A00, "mod_add");
  endtask

  task automatic test_mod_sub();
    run_addsub(1'b1, 32, 'h0B00, "mod_sub");
  endtask

  task automatic test_cond_jump();
    int     err0;
    slot_t  s;
    err0 = errors;
    s    = mk_slot(FE, rand_fe());
    write_inst(48, JUMP_IF_EQ, 51, 50, 51);
    write_inst(49, SEND_INTERRUPT, 50, 'h00E1, 1);
    write_inst(50, NOOP_WAIT, 0, 0, 0);
    write_inst(51, SEND_INTERRUPT, 50, 'h00E0, 1);
    write_inst(52, NOOP_WAIT, 0, 0, 0);
    exp_q.delete();
    exp_q.push_back(s);
    // Equal slots take the jump
    write_slot(50, s);
    write_slot(51, s);
    start_prog(48);
    collect_packet(16'h00E0, FE, 1'b0);
    expect_quiet(QUIET_CYCLES);
    // Unequal slots fall through
    write_slot(51, mk_slot(FE, s.dat ^ 32'h1));
    start_prog(48);
    collect_packet(16'h00E1, FE, 1'b0);
    expect_quiet(QUIET_CYCLES);
    end_test("cond_jump", err0);
  endtask

  task automatic test_counted_loop();
    int           err0;
    logic [31:0]  acc;
    err0 = errors;
    acc  = rand_fe();
    write_slot(60, mk_slot(SCALAR, 32'd5));
    write_slot(61, mk_slot(FE, acc));
    write_inst(64, ADD_ELEMENT, 61, 61, 61);
    write_inst(65, JUMP_NONZERO_SUB, 64, 60, 0);
    write_inst(66, SEND_INTERRUPT, 60, 'h0C05, 2);
    write_inst(67, NOOP_WAIT, 0, 0, 0);
    // Body runs once per count plus once more at zero
    repeat (6) acc = mod_add(acc, acc);
    exp_q.delete();
    exp_q.push_back(mk_slot(SCALAR, 32'd0));
    exp_q.push_back(mk_slot(FE, acc));
    start_prog(64);
    collect_packet(16'h0C05, SCALAR, 1'b0);
    expect_quiet(QUIET_CYCLES);
    end_test("counted_loop", err0);
  endtask

  task automatic test_backpressure();
    int     err0;
    int     cycles;
    slot_t  s;
    err0 = errors;
    exp_q.delete();
    for (int i = 0; i < 6; i++) begin
      if ((i % 3) == 0) begin
        s = mk_slot(SCALAR, rand_fe());
      end else begin
        s = mk_slot(FE, rand_fe());
      end
      write_slot(70 + i, s);
      exp_q.push_back(s);
    end
    write_inst(80, SEND_INTERRUPT, 70, 'h00B6, 6);
    write_inst(81, NOOP_WAIT, 0, 0, 0);
    // Stall the stream so a beat is pending when reset hits
    i_tx_rdy = 1'b0;
    start_prog(80);
    cycles = 0;
    while (!o_tx_val && cycles < PKT_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    check_true(o_tx_val, "no beat was offered on the stalled stream before the reset");
    apply_reset();
    check_true(!o_tx_val, "o_tx_val was high right after reset");
    start_prog(80);
    collect_packet(16'h00B6, exp_q[0].tag, 1'b1);
    expect_quiet(QUIET_CYCLES);
    end_test("backpressure", err0);
  endtask

  initial begin
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_usr_wr_en = 1'b0;
    i_usr_wr    = '0;
    i_start     = 1'b0;
    i_start_pt  = '0;
    i_tx_rdy    = 1'b1;
    seed        = 32'h4192;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    apply_reset();
    test_copy_send();
    test_mod_add();
    test_mod_sub();
    test_cond_jump();
    test_counted_loop();
    test_backpressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
